/* build.f */
+incdir+sim
hdl/saturn_bus_pkg.sv
hdl/saturn_bus_regs.sv
hdl/saturn_bus_ctrl.sv
hdl/saturn_sysram.sv
hdl/saturn_bus_top.sv
sim/tb_saturn_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the Saturn bus testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_saturn_bus \
    -f build.f \
    -Mdir obj_dir

# A failed check ends the simulation with a non-zero status, keep its output anyway
output="$(./obj_dir/Vtb_saturn_bus || true)"
echo "$output"

if grep -qx ">>> PASS" <<< "$output"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

/* sim/tb_saturn_bus_model.svh */
//----------------------------------------
// Saturn bus reference model
// Predicts read nibbles and hit, and holds
// the Wishbone host tasks and value check
//----------------------------------------

// Pointers every RAM block tracks on its own
logic [ADDR_W-1:0] m_pc;
logic [ADDR_W-1:0] m_dp;
logic [ADDR_W-1:0] m_base [2];
logic [ADDR_W-1:0] m_size [2];
logic              m_size_ok [2];
logic              m_base_ok [2];
// Sparse contents keyed by RAM index and window offset
logic [3:0]        m_mem [int];

task automatic model_reset();
    m_pc = '0;
    m_dp = '0;
    for (int r = 0; r < 2; r++) begin
        m_size_ok[r] = 1'b0;
        m_base_ok[r] = 1'b0;
    end
endtask

function automatic logic in_window(input int r, input logic [ADDR_W-1:0] ptr);
    return m_size_ok[r] && m_base_ok[r] && (ptr >= m_base[r]) && (ptr - m_base[r] < m_size[r]);
endfunction

// Returns {hit, read nibbles} for one bus command
function automatic logic [32:0] predict_cmd(input saturn_buscmd_e op, input int count,
                                            input logic [31:0] wdata);
    logic [31:0]       rdata;
    logic              hit;
    logic [3:0]        nib;
    logic [3:0]        rd;
    logic [ADDR_W-1:0] ptr;
    logic              sel [2];
    saturn_buscmd_e    last;
    int                pos;
    int                key;
    rdata = 32'd0;
    hit   = 1'b0;
    last  = op;
    pos   = 0;
    // Daisy chain picks the first unconfigured block
    sel[0] = !(m_size_ok[0] && m_base_ok[0]);
    sel[1] = !sel[0] && !(m_size_ok[1] && m_base_ok[1]);
    if (op == RESET) begin
        model_reset_config();
    end
    for (int k = 0; k < count; k++) begin
        nib = (op == PC_READ || op == DP_READ) ? 4'd0 : wdata[4*k +: 4];
        rd  = 4'd0;
        hit = 1'b0;
        case (last)
            PC_READ, DP_READ, PC_WRITE, DP_WRITE: begin
                ptr = (last == PC_READ || last == PC_WRITE) ? m_pc : m_dp;
                for (int r = 0; r < 2; r++) begin
                    if (in_window(r, ptr)) begin
                        hit = 1'b1;
                        key = r * (1 << ADDR_W) + int'(ptr - m_base[r]);
                        if (last == PC_READ || last == DP_READ) begin
                            if (m_mem.exists(key)) begin
                                rd = rd | m_mem[key];
                            end
                        end else begin
                            m_mem[key] = nib;
                        end
                    end
                end
                if (last == PC_READ || last == PC_WRITE) begin
                    m_pc = ptr + 1'b1;
                end else begin
                    m_dp = ptr + 1'b1;
                end
            end
            LOAD_PC, LOAD_DP: begin
                if (pos < ADDR_NIBBLES) begin
                    if (last == LOAD_PC) begin
                        m_pc[4*pos +: 4] = nib;
                    end else begin
                        m_dp[4*pos +: 4] = nib;
                    end
                    pos++;
                    if (pos == ADDR_NIBBLES) begin
                        last = (last == LOAD_PC) ? PC_READ : DP_READ;
                    end
                end
            end
            CONFIGURE: begin
                for (int r = 0; r < 2; r++) begin
                    if (sel[r] && pos < ADDR_NIBBLES) begin
                        if (!m_size_ok[r]) begin
                            m_size[r][4*pos +: 4] = nib;
                            if (pos == ADDR_NIBBLES - 1) begin
                                // Size travels negated
                                m_size[r]    = -m_size[r];
                                m_size_ok[r] = 1'b1;
                            end
                        end else begin
                            m_base[r][4*pos +: 4] = nib;
                            if (pos == ADDR_NIBBLES - 1) begin
                                m_base_ok[r] = 1'b1;
                            end
                        end
                    end
                end
                pos++;
            end
            default: begin
            end
        endcase
        rdata[4*k +: 4] = rd;
    end
    return {hit, rdata};
endfunction

function automatic void model_reset_config();
    for (int r = 0; r < 2; r++) begin
        m_size_ok[r] = 1'b0;
        m_base_ok[r] = 1'b0;
    end
endfunction

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first mismatch");
    end
endtask

//----------------------------------------
// Wishbone host access
//----------------------------------------
task automatic end_access();
    int waits;
    waits = 0;
    @(posedge i_clk);
    while (!wb_ack) begin
        waits++;
        @(posedge i_clk);
    end
    // Ack comes one cycle after the strobe and is low again before the next access
    check("wb ack latency", 32'd1, 32'(waits));
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
endtask

task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
    @(posedge i_clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b1;
    wb_adr <= adr;
    wb_dat <= dat;
    end_access();
endtask

task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
    @(posedge i_clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    end_access();
    // Read data is valid while ack is high
    dat = wb_rdat;
endtask

/* sim/tb_saturn_bus.sv */
//----------------------------------------
// Saturn bus subsystem testbench
// Host command sequences checked against
// the reference model
//----------------------------------------
`timescale 1ns/10ps

module tb_saturn_bus;
    import saturn_bus_pkg::*;

    // About 60 commands of up to 18 bus cycles each, plus polling
    localparam int MAX_CYCLES = 4000;

    logic        i_clk;
    logic        i_reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic [31:0] wb_rdat;
    int          cycles;
    int          seed;

    `include "tb_saturn_bus_model.svh"

    saturn_bus_top saturn_bus_top_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat),
        .o_wb_ack (wb_ack),
        .o_wb_dat (wb_rdat)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Timeout");
        end
    end

    task automatic wait_idle(output logic [31:0] status);
        status = 32'd1;
        while (status[0]) begin
            wb_read(REG_STATUS, status);
        end
    endtask

    // One bus command with its read nibbles and hit checked against the model
    task automatic run_cmd(input string name, input saturn_buscmd_e op, input int count,
                           input logic [31:0] wdata, output logic [31:0] rd,
                           output logic hit);
        logic [32:0] expected;
        logic [31:0] status;
        wb_write(REG_DATA, wdata);
        wb_write(REG_CMD, {24'd0, 4'(count), op});
        expected = predict_cmd(op, count, wdata);
        wait_idle(status);
        wb_read(REG_DATA, rd);
        hit = status[1];
        check({name, " data"}, expected[31:0], rd);
        check({name, " hit"}, {31'd0, expected[32]}, {31'd0, hit});
    endtask

    // RAM 0 at 0x10000 size 0x400, RAM 1 at 0x20000 size 0x100, then one extra
    task automatic configure_all();
        logic [31:0] rd;
        logic        hit;
        run_cmd("ram0 size", CONFIGURE, 5, 32'h000F_FC00, rd, hit);
        run_cmd("ram0 base", CONFIGURE, 5, 32'h0001_0000, rd, hit);
        run_cmd("ram1 size", CONFIGURE, 5, 32'h000F_FF00, rd, hit);
        run_cmd("ram1 base", CONFIGURE, 5, 32'h0002_0000, rd, hit);
        run_cmd("extra configure", CONFIGURE, 5, 32'h0003_0000, rd, hit);
    endtask

    initial begin : test_seq
        logic [31:0]       rd;
        logic [31:0]       status;
        logic [31:0]       wdata;
        logic [31:0]       pc_data;
        logic [32:0]       expected;
        logic [ADDR_W-1:0] addr;
        logic              hit;
        int                t0;
        i_clk   = 1'b0;
        i_reset = 1'b1;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = 2'd0;
        wb_dat  = 32'd0;
        cycles  = 0;
        seed    = 4630;
        model_reset();
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;

        // Register access, busy and a refused command
        wb_read(REG_STATUS, status);
        check("status after reset", 32'd0, status);
        wdata = $random(seed);
        wb_write(REG_DATA, wdata);
        wb_read(REG_DATA, rd);
        check("data readback", wdata, rd);
        wb_write(REG_DATA, 32'd0);
        wb_write(REG_CMD, {24'd0, 4'd8, DP_READ});
        t0 = cycles;
        expected = predict_cmd(DP_READ, 8, 32'd0);
        wb_read(REG_STATUS, status);
        check("busy while running", 32'd1, {31'd0, status[0]});
        // Would shift the daisy chain if it were taken
        wb_write(REG_CMD, {24'd0, 4'd5, CONFIGURE});
        wait_idle(status);
        // 18 busy cycles plus up to 4 cycles of poll latency
        check("busy length", 32'd1, {31'd0, (cycles - t0 >= 18) && (cycles - t0 <= 22)});
        wb_read(REG_DATA, rd);
        check("first read data", expected[31:0], rd);
        check("first read hit", {31'd0, expected[32]}, {31'd0, status[1]});

        configure_all();

        // DP write and read back inside RAM 0
        for (int i = 0; i < 4; i++) begin
            addr  = 20'h10000 + 20'($unsigned($random(seed)) % 1017);
            wdata = $random(seed);
            run_cmd("ram0 load dp", LOAD_DP, 5, {12'd0, addr}, rd, hit);
            run_cmd("ram0 dp write", DP_WRITE, 8, wdata, rd, hit);
            run_cmd("ram0 reload dp", LOAD_DP, 5, {12'd0, addr}, rd, hit);
            run_cmd("ram0 dp read", DP_READ, 8, 32'd0, rd, hit);
            check("ram0 dp value", wdata, rd);
            check("ram0 dp hit", 32'd1, {31'd0, hit});
        end

        // PC access running off the end of RAM 1
        pc_data = $random(seed);
        run_cmd("ram1 load pc", LOAD_PC, 5, 32'h0002_00FC, rd, hit);
        run_cmd("ram1 pc write", PC_WRITE, 8, pc_data, rd, hit);
        run_cmd("ram1 reload pc", LOAD_PC, 5, 32'h0002_00FC, rd, hit);
        run_cmd("ram1 pc read", PC_READ, 8, 32'd0, rd, hit);
        check("ram1 window edge", {16'd0, pc_data[15:0]}, rd);

        // Nothing mapped here
        run_cmd("unmapped load dp", LOAD_DP, 5, 32'h0003_0000, rd, hit);
        run_cmd("unmapped dp read", DP_READ, 8, 32'd0, rd, hit);
        check("unmapped value", 32'd0, rd);
        check("unmapped hit", 32'd0, {31'd0, hit});

        // Bus RESET drops the windows but keeps the contents
        run_cmd("bus reset", RESET, 0, 32'd0, rd, hit);
        run_cmd("old window load dp", LOAD_DP, 5, {12'd0, addr}, rd, hit);
        run_cmd("old window dp read", DP_READ, 8, 32'd0, rd, hit);
        check("old window value", 32'd0, rd);
        check("old window hit", 32'd0, {31'd0, hit});
        configure_all();
        run_cmd("restored load dp", LOAD_DP, 5, {12'd0, addr}, rd, hit);
        run_cmd("restored dp read", DP_READ, 8, 32'd0, rd, hit);
        check("restored ram0 value", wdata, rd);
        run_cmd("restored load pc", LOAD_PC, 5, 32'h0002_00FC, rd, hit);
        run_cmd("restored pc read", PC_READ, 8, 32'd0, rd, hit);
        check("restored ram1 value", {16'd0, pc_data[15:0]}, rd);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* hdl/saturn_bus_top.sv */
//----------------------------------------
// Saturn bus subsystem top
// Host registers, sequencer and two RAMs
//----------------------------------------
`timescale 1ns/10ps

module saturn_bus_top (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [1:0]  i_wb_adr,
    input  logic [31:0] i_wb_dat,
    output logic        o_wb_ack,
    output logic [31:0] o_wb_dat
);
    import saturn_bus_pkg::*;

    logic           start;
    saturn_buscmd_e opcode;
    logic [3:0]     count;
    logic [31:0]    wdata;
    logic           busy;
    logic [31:0]    rdata;
    logic           hit;

    // Shared nibble bus
    logic                bus_strobe;
    logic                bus_is_data;
    logic [NIBBLE_W-1:0] bus_nibble;
    logic [NIBBLE_W-1:0] ram0_nibble;
    logic [NIBBLE_W-1:0] ram1_nibble;
    logic                ram0_active;
    logic                ram1_active;
    logic                daisy_0_to_1;

    saturn_bus_regs saturn_bus_regs_inst (
        .i_clk    (i_clk),    .i_reset (i_reset),
        .i_wb_cyc (i_wb_cyc), .i_wb_stb (i_wb_stb), .i_wb_we (i_wb_we),
        .i_wb_adr (i_wb_adr), .i_wb_dat (i_wb_dat),
        .i_busy   (busy),     .i_rdata  (rdata),    .i_hit   (hit),
        .o_wb_ack (o_wb_ack), .o_wb_dat (o_wb_dat), .o_start (start),
        .o_opcode (opcode),   .o_count  (count),    .o_wdata (wdata)
    );

    saturn_bus_ctrl saturn_bus_ctrl_inst (
        .i_clk           (i_clk),    .i_reset (i_reset),
        .i_start         (start),    .i_opcode (opcode),
        .i_count         (count),    .i_wdata  (wdata),
        .i_bus_nibble_in (ram0_nibble | ram1_nibble),
        .i_bus_active    (ram0_active | ram1_active),
        .o_busy          (busy),     .o_rdata  (rdata),  .o_hit (hit),
        .o_bus_strobe    (bus_strobe),
        .o_bus_is_data   (bus_is_data),
        .o_bus_nibble    (bus_nibble)
    );

    // Head of the daisy chain is always enabled
    saturn_sysram #(.ADDR_BITS(SYSRAM0_BITS)) sysram0 (
        .i_clk (i_clk), .i_reset (i_reset),
        .i_bus_strobe (bus_strobe), .i_bus_is_data (bus_is_data),
        .i_bus_nibble (bus_nibble), .i_daisy (1'b1),
        .o_bus_nibble_out (ram0_nibble), .o_bus_active (ram0_active),
        .o_daisy (daisy_0_to_1)
    );

    saturn_sysram #(.ADDR_BITS(SYSRAM1_BITS)) sysram1 (
        .i_clk (i_clk), .i_reset (i_reset),
        .i_bus_strobe (bus_strobe), .i_bus_is_data (bus_is_data),
        .i_bus_nibble (bus_nibble), .i_daisy (daisy_0_to_1),
        .o_bus_nibble_out (ram1_nibble), .o_bus_active (ram1_active),
        .o_daisy ()
    );

endmodule

/* hdl/saturn_sysram.sv */
//----------------------------------------
// Saturn system RAM
// Daisy-chain configured nibble memory
// addressed through its own PC and DP
//----------------------------------------
`timescale 1ns/10ps

module saturn_sysram #(
    parameter int ADDR_BITS = saturn_bus_pkg::SYSRAM0_BITS
) (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_bus_strobe,
    input  logic                                i_bus_is_data,
    input  logic [saturn_bus_pkg::NIBBLE_W-1:0] i_bus_nibble,
    input  logic                                i_daisy,
    output logic [saturn_bus_pkg::NIBBLE_W-1:0] o_bus_nibble_out,
    output logic                                o_bus_active,
    output logic                                o_daisy
);
    import saturn_bus_pkg::*;

    logic [NIBBLE_W-1:0] mem [0:(2**ADDR_BITS)-1];

    saturn_buscmd_e    last_cmd;
    logic [2:0]        pos;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] dp;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] size;
    logic              size_conf;
    logic              base_conf;
    // This block owns the CONFIGURE in progress
    logic              cfg_sel;

    logic              configured;
    logic              cmd_strobe;
    logic              data_strobe;
    logic              pos_valid;
    logic              last_pos;
    logic              use_pc;
    logic              do_read;
    logic              do_write;
    logic [ADDR_W-1:0] pointer;
    logic [ADDR_W-1:0] offset;
    logic              in_window;

    assign configured  = size_conf && base_conf;
    assign o_daisy     = configured;
    assign cmd_strobe  = i_bus_strobe && !i_bus_is_data;
    assign data_strobe = i_bus_strobe && i_bus_is_data;
    assign pos_valid   = (pos < 3'(ADDR_NIBBLES));
    assign last_pos    = (pos == 3'(ADDR_NIBBLES - 1));

    //----------------------------------------
    // Window decode
    //----------------------------------------
    assign use_pc   = (last_cmd == PC_READ) || (last_cmd == PC_WRITE);
    assign do_read  = (last_cmd == PC_READ) || (last_cmd == DP_READ);
    assign do_write = (last_cmd == PC_WRITE) || (last_cmd == DP_WRITE);
    assign pointer  = use_pc ? pc : dp;
    assign offset   = pointer - base;
    // Offset compare avoids overflow of base + size
    assign in_window = configured && (pointer >= base) && (offset < size);

    always_ff @(posedge i_clk) begin
        if (data_strobe && do_write && in_window) begin
            mem[offset[ADDR_BITS-1:0]] <= i_bus_nibble;
        end
    end

    // Read nibble and active flag are registered on the strobe edge
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bus_nibble_out <= '0;
            o_bus_active     <= 1'b0;
        end else if (data_strobe) begin
            o_bus_active     <= in_window && (do_read || do_write);
            o_bus_nibble_out <= (in_window && do_read) ? mem[offset[ADDR_BITS-1:0]] : '0;
        end else if (cmd_strobe) begin
            o_bus_nibble_out <= '0;
            o_bus_active     <= 1'b0;
        end
    end

    //----------------------------------------
    // Command decode, pointers, configuration
    //----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd  <= PC_READ;
            pos       <= 3'd0;
            pc        <= '0;
            dp        <= '0;
            size_conf <= 1'b0;
            base_conf <= 1'b0;
            cfg_sel   <= 1'b0;
        end else if (cmd_strobe) begin
            last_cmd <= saturn_buscmd_e'(i_bus_nibble);
            pos      <= 3'd0;
            cfg_sel  <= i_daisy && !configured;
            if (saturn_buscmd_e'(i_bus_nibble) == RESET) begin
                size_conf <= 1'b0;
                base_conf <= 1'b0;
            end
        end else if (data_strobe) begin
            case (last_cmd)
                PC_READ, PC_WRITE: pc <= pc + 1'b1;
                DP_READ, DP_WRITE: dp <= dp + 1'b1;
                LOAD_PC: begin
                    if (pos_valid) begin
                        pc[pos*NIBBLE_W +: NIBBLE_W] <= i_bus_nibble;
                        pos <= pos + 3'd1;
                        if (last_pos) begin
                            last_cmd <= PC_READ;
                        end
                    end
                end
                LOAD_DP: begin
                    if (pos_valid) begin
                        dp[pos*NIBBLE_W +: NIBBLE_W] <= i_bus_nibble;
                        pos <= pos + 3'd1;
                        if (last_pos) begin
                            last_cmd <= DP_READ;
                        end
                    end
                end
                CONFIGURE: begin
                    if (cfg_sel && pos_valid) begin
                        pos <= pos + 3'd1;
                        if (!size_conf) begin
                            // Size arrives as its two's complement
                            if (last_pos) begin
                                size      <= ~{i_bus_nibble, size[ADDR_W-NIBBLE_W-1:0]} + 1'b1;
                                size_conf <= 1'b1;
                            end else begin
                                size[pos*NIBBLE_W +: NIBBLE_W] <= i_bus_nibble;
                            end
                        end else begin
                            base[pos*NIBBLE_W +: NIBBLE_W] <= i_bus_nibble;
                            if (last_pos) begin
                                base_conf <= 1'b1;
                            end
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* hdl/saturn_bus_ctrl.sv */
//----------------------------------------
// Saturn bus sequencer
// Plays one command slot and its data slots
// and collects the returned nibbles
//----------------------------------------
`timescale 1ns/10ps

module saturn_bus_ctrl (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_start,
    input  saturn_bus_pkg::saturn_buscmd_e i_opcode,
    input  logic [3:0]                     i_count,
    input  logic [31:0]                    i_wdata,
    input  logic [3:0]                     i_bus_nibble_in,
    input  logic                           i_bus_active,
    output logic                           o_busy,
    output logic [31:0]                    o_rdata,
    output logic                           o_hit,
    output logic                           o_bus_strobe,
    output logic                           o_bus_is_data,
    output logic [3:0]                     o_bus_nibble
);
    import saturn_bus_pkg::*;

    seq_state_e     state;
    // Second cycle of the command slot
    logic           cmd_phase;
    saturn_buscmd_e opcode_q;
    logic [3:0]     count_q;
    logic [31:0]    wdata_q;
    logic [3:0]     slot;
    logic           is_read;

    assign is_read       = (opcode_q == PC_READ) || (opcode_q == DP_READ);
    assign o_busy        = (state != IDLE);
    assign o_bus_strobe  = ((state == CMD_SLOT) && !cmd_phase) || (state == DATA_STROBE);
    assign o_bus_is_data = (state == DATA_STROBE);

    // Reads put zero on the bus, everything else sends the data nibble
    always_comb begin
        case (state)
            CMD_SLOT:    o_bus_nibble = opcode_q;
            DATA_STROBE: o_bus_nibble = is_read ? 4'd0 : wdata_q[slot[2:0]*NIBBLE_W +: NIBBLE_W];
            default:     o_bus_nibble = 4'd0;
        endcase
    end

    //----------------------------------------
    // Slot FSM
    //----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= IDLE;
            cmd_phase <= 1'b0;
            slot      <= 4'd0;
            o_hit     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state     <= CMD_SLOT;
                        cmd_phase <= 1'b0;
                        slot      <= 4'd0;
                        o_hit     <= 1'b0;
                    end
                end
                CMD_SLOT: begin
                    cmd_phase <= 1'b1;
                    if (cmd_phase) begin
                        state <= (count_q == 4'd0) ? IDLE : DATA_STROBE;
                    end
                end
                DATA_STROBE: begin
                    state <= DATA_CAPTURE;
                end
                DATA_CAPTURE: begin
                    // Hit follows the most recent data slot
                    o_hit <= i_bus_active;
                    slot  <= slot + 4'd1;
                    state <= (slot + 4'd1 == count_q) ? IDLE : DATA_STROBE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Command payload and collected nibbles
    always_ff @(posedge i_clk) begin
        if ((state == IDLE) && i_start) begin
            opcode_q <= i_opcode;
            count_q  <= i_count;
            wdata_q  <= i_wdata;
            o_rdata  <= 32'd0;
        end else if (state == DATA_CAPTURE) begin
            o_rdata[slot[2:0]*NIBBLE_W +: NIBBLE_W] <= i_bus_nibble_in;
        end
    end

endmodule

/* hdl/saturn_bus_regs.sv */
//----------------------------------------
// Saturn bus host registers
// Wishbone classic slave holding command,
// data and status for the bus sequencer
//----------------------------------------
`timescale 1ns/10ps

module saturn_bus_regs (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_wb_cyc,
    input  logic                           i_wb_stb,
    input  logic                           i_wb_we,
    input  logic [1:0]                     i_wb_adr,
    input  logic [31:0]                    i_wb_dat,
    input  logic                           i_busy,
    input  logic [31:0]                    i_rdata,
    input  logic                           i_hit,
    output logic                           o_wb_ack,
    output logic [31:0]                    o_wb_dat,
    output logic                           o_start,
    output saturn_bus_pkg::saturn_buscmd_e o_opcode,
    output logic [3:0]                     o_count,
    output logic [31:0]                    o_wdata
);
    import saturn_bus_pkg::*;

    logic        wb_access;
    logic        wb_write;
    logic [3:0]  cmd_count;
    logic [31:0] data_q;
    // Set by a host DATA write, cleared when a command starts
    logic        data_fresh;

    assign wb_access = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wb_write  = wb_access && i_wb_we;

    //----------------------------------------
    // Command launch
    //----------------------------------------
    // The sequencer takes the command on the same edge that acks the write
    assign o_start   = wb_write && (i_wb_adr == REG_CMD) && !i_busy;
    assign o_opcode  = saturn_buscmd_e'(i_wb_dat[3:0]);
    assign cmd_count = i_wb_dat[7:4];
    assign o_count   = (cmd_count > 4'(MAX_DATA_NIBBLES)) ? 4'(MAX_DATA_NIBBLES) : cmd_count;
    assign o_wdata   = data_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_access;
        end
    end

    // Write nibbles, rejected while a command runs
    always_ff @(posedge i_clk) begin
        if (wb_write && (i_wb_adr == REG_DATA) && !i_busy) begin
            data_q <= i_wb_dat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            data_fresh <= 1'b0;
        end else if (o_start) begin
            data_fresh <= 1'b0;
        end else if (wb_write && (i_wb_adr == REG_DATA) && !i_busy) begin
            data_fresh <= 1'b1;
        end
    end

    //----------------------------------------
    // Read data, valid while ack is high
    //----------------------------------------
    always_ff @(posedge i_clk) begin
        if (wb_access) begin
            case (i_wb_adr)
                REG_DATA:   o_wb_dat <= data_fresh ? data_q : i_rdata;
                REG_STATUS: o_wb_dat <= {30'd0, i_hit, i_busy};
                default:    o_wb_dat <= 32'd0;
            endcase
        end
    end

endmodule

/* hdl/saturn_bus_pkg.sv */
//----------------------------------------
// Saturn nibble bus package
// Bus opcodes, sequencer states, widths
// and the host register map
//----------------------------------------
package saturn_bus_pkg;

    //----------------------------------------
    // Widths
    //----------------------------------------
    localparam int NIBBLE_W         = 4;
    localparam int ADDR_W           = 20;
    localparam int ADDR_NIBBLES     = 5;
    localparam int MAX_DATA_NIBBLES = 8;

    // Depths of the two RAM blocks, in address bits
    localparam int SYSRAM0_BITS = 10;
    localparam int SYSRAM1_BITS = 8;

    //----------------------------------------
    // Host register map (word addresses)
    //----------------------------------------
    localparam logic [1:0] REG_CMD    = 2'd0;
    localparam logic [1:0] REG_DATA   = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;

    // Opcodes carried in the command slot
    typedef enum logic [NIBBLE_W-1:0] {
        PC_READ   = 4'd0,
        DP_READ   = 4'd1,
        PC_WRITE  = 4'd2,
        DP_WRITE  = 4'd3,
        LOAD_PC   = 4'd4,
        LOAD_DP   = 4'd5,
        CONFIGURE = 4'd6,
        RESET     = 4'd10
    } saturn_buscmd_e;

    // Sequencer FSM states
    typedef enum logic [1:0] {
        IDLE,
        CMD_SLOT,
        DATA_STROBE,
        DATA_CAPTURE
    } seq_state_e;

endpackage
